//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = frame_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
common/frame_pkg.sv
board/board_reset.sv
board/board_inputs.sv
hdl/video_expand.sv
hdl/snd_dac.sv
hdl/frame_top.sv
verification/frame_tb.sv

//--- board/board_inputs.sv
// --------------------
// Outputs are registered, one cycle after the inputs
// Game inputs sit at their idle level while rst is high
// DIP outputs carry no reset and follow the status word
// --------------------

`timescale 1ns/1ps

module board_inputs
    import frame_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic [board_joy_w-1:0] board_joystick1,
    input  logic [board_joy_w-1:0] board_joystick2,
    input  logic [status_w-1:0]    status,
    output logic [joy_w-1:0]       game_joystick1,
    output logic [joy_w-1:0]       game_joystick2,
    output logic [1:0]             game_coin,
    output logic [1:0]             game_start,
    output logic                   game_pause,
    output logic                   game_service,
    output logic                   dip_test,
    output logic                   dip_pause,
    output logic                   dip_flip,
    output logic [1:0]             dip_fxlevel,
    output logic                   enable_fm,
    output logic                   enable_psg
);

    logic pause_q;
    logic pause_flag;
    logic pause_next;

    // Rising edge of player 1 pause toggles the flag
    assign pause_next = pause_flag ^ (board_joystick1[joy_pause_bit] & ~pause_q);

    always_ff @(posedge clk_sys) begin
        pause_q <= board_joystick1[joy_pause_bit];
        if (rst) begin
            game_joystick1 <= joy_idle;
            game_joystick2 <= joy_idle;
            game_coin      <= {2{inputs_active_low}};
            game_start     <= {2{inputs_active_low}};
            game_service   <= inputs_active_low;
            pause_flag     <= 1'b0;
            game_pause     <= 1'b0;
        end else begin
            game_joystick1 <= board_joystick1[joy_w-1:0] ^ joy_idle;
            game_joystick2 <= board_joystick2[joy_w-1:0] ^ joy_idle;
            // Bit 0 is player 1
            game_coin    <= {board_joystick2[joy_coin_bit], board_joystick1[joy_coin_bit]}
                            ^ {2{inputs_active_low}};
            game_start   <= {board_joystick2[joy_start_bit], board_joystick1[joy_start_bit]}
                            ^ {2{inputs_active_low}};
            game_service <= board_joystick1[joy_service_bit] ^ inputs_active_low;
            pause_flag   <= pause_next;
            game_pause   <= pause_next | status[st_pause_bit];
        end
    end

    // Status decoding
    always_ff @(posedge clk_sys) begin
        dip_test    <= status[st_test_bit];
        dip_pause   <= status[st_pause_bit];
        dip_flip    <= status[st_flip_bit];
        dip_fxlevel <= status[st_fx_lsb +: 2];
        enable_fm   <= ~status[st_nofm_bit];
        enable_psg  <= ~status[st_nopsg_bit];
    end

    // Controls released right after reset
    a_joy_idle: assert property (@(posedge clk_sys) rst |=> game_joystick1 == joy_idle)
        else $error("game_joystick1 not idle after rst");

endmodule

//--- board/board_reset.sv
// --------------------
// Board reset follows reset and PLL lock with one cycle of delay
// Game reset is stretched rst_hold cycles past its last cause
// A change of dip_flip counts as a game reset cause
// --------------------

`timescale 1ns/1ps

module board_reset
    import frame_pkg::*;
(
    input  logic clk_sys,
    input  logic reset,
    input  logic pll_locked,
    input  logic downloading,
    input  logic rst_req,
    input  logic dip_flip,
    output logic rst,
    output logic game_rst,
    output logic led
);

    logic [rst_cnt_w-1:0] hold_cnt;
    logic                 flip_q;
    logic                 flip_chg;
    logic                 cause;

    assign flip_chg = dip_flip ^ flip_q;
    assign cause    = rst | downloading | rst_req | flip_chg;

    // Counter reloads while any cause is present
    always_ff @(posedge clk_sys) begin
        flip_q <= dip_flip;
        if (reset) begin
            rst      <= 1'b1;
            hold_cnt <= rst_cnt_w'(rst_hold);
        end else begin
            rst <= ~pll_locked;
            if (cause) begin
                hold_cnt <= rst_cnt_w'(rst_hold);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    assign game_rst = cause | (hold_cnt != '0);

    // LED dark while anything holds the board
    assign led = ~(rst | downloading | ~pll_locked);

    // Board reset always implies game reset
    a_rst_covered: assert property (@(posedge clk_sys) rst |-> game_rst)
        else $error("game_rst low while rst is high");

endmodule

//--- common/frame_pkg.sv
// --------------------
// Widths, bit positions and build options of the board frame
// Status and controller layouts follow the I/O controller word format
// Sound is unsigned and game inputs are active low in this build
// --------------------

package frame_pkg;

    // Data widths
    localparam int color_w     = 4;
    localparam int vga_w       = 6;
    localparam int joy_w       = 10;
    localparam int board_joy_w = 16;
    localparam int status_w    = 32;
    localparam int snd_w       = 16;

    // Build options
    localparam bit signed_snd        = 1'b0;
    localparam bit inputs_active_low = 1'b1;

    // Game reset stretch, in clk_sys cycles
    localparam int rst_hold  = 16;
    localparam int rst_cnt_w = $clog2(rst_hold + 1);

    // Idle level of a game joystick word
    localparam logic [joy_w-1:0] joy_idle = {joy_w{inputs_active_low}};

    // Board controller word
    localparam int joy_coin_bit    = 10;
    localparam int joy_start_bit   = 11;
    localparam int joy_pause_bit   = 12;
    localparam int joy_service_bit = 13;

    // Status word
    localparam int st_test_bit  = 10;
    localparam int st_pause_bit = 11;
    localparam int st_flip_bit  = 12;
    localparam int st_fx_lsb    = 13;
    localparam int st_nofm_bit  = 15;
    localparam int st_nopsg_bit = 16;

endpackage

//--- hdl/frame_top.sv
// --------------------
// Single clock frame, everything runs on clk_sys
// Status and controller words arrive as plain levels
// --------------------

`timescale 1ns/1ps

module frame_top
    import frame_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   pll_locked,
    input  logic [status_w-1:0]    status,
    input  logic [board_joy_w-1:0] board_joystick1,
    input  logic [board_joy_w-1:0] board_joystick2,
    input  logic                   downloading,
    input  logic                   rst_req,
    input  logic [color_w-1:0]     game_r,
    input  logic [color_w-1:0]     game_g,
    input  logic [color_w-1:0]     game_b,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic                   hs,
    input  logic                   vs,
    input  logic                   pxl_cen,
    input  logic [snd_w-1:0]       snd_left,
    input  logic [snd_w-1:0]       snd_right,
    output logic                   rst,
    output logic                   game_rst,
    output logic                   led,
    output logic [vga_w-1:0]       vga_r,
    output logic [vga_w-1:0]       vga_g,
    output logic [vga_w-1:0]       vga_b,
    output logic                   vga_hs,
    output logic                   vga_vs,
    output logic                   audio_l,
    output logic                   audio_r,
    output logic [joy_w-1:0]       game_joystick1,
    output logic [joy_w-1:0]       game_joystick2,
    output logic [1:0]             game_coin,
    output logic [1:0]             game_start,
    output logic                   game_pause,
    output logic                   game_service,
    output logic                   dip_test,
    output logic                   dip_pause,
    output logic                   dip_flip,
    output logic [1:0]             dip_fxlevel,
    output logic                   enable_fm,
    output logic                   enable_psg
);

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .reset       ( reset       ),
        .pll_locked  ( pll_locked  ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .dip_flip    ( dip_flip    ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    ),
        .led         ( led         )
    );

    // Inputs are held idle by the game reset
    board_inputs u_inputs (
        .clk_sys         ( clk_sys         ),
        .rst             ( game_rst        ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .status          ( status          ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      ),
        .game_service    ( game_service    ),
        .dip_test        ( dip_test        ),
        .dip_pause       ( dip_pause       ),
        .dip_flip        ( dip_flip        ),
        .dip_fxlevel     ( dip_fxlevel     ),
        .enable_fm       ( enable_fm       ),
        .enable_psg      ( enable_psg      )
    );

    video_expand u_video (
        .clk_sys ( clk_sys ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .vga_r   ( vga_r   ),
        .vga_g   ( vga_g   ),
        .vga_b   ( vga_b   ),
        .vga_hs  ( vga_hs  ),
        .vga_vs  ( vga_vs  )
    );

    snd_dac u_snd_l (
        .clk_sys ( clk_sys  ),
        .rst     ( rst      ),
        .sample  ( snd_left ),
        .pdm     ( audio_l  )
    );

    snd_dac u_snd_r (
        .clk_sys ( clk_sys   ),
        .rst     ( rst       ),
        .sample  ( snd_right ),
        .pdm     ( audio_r   )
    );

endmodule

//--- hdl/snd_dac.sv
// --------------------
// First-order sigma-delta, one output bit per clk_sys cycle
// Signed samples are moved to offset binary when signed_snd is set
// --------------------

`timescale 1ns/1ps

module snd_dac
    import frame_pkg::*;
(
    input  logic             clk_sys,
    input  logic             rst,
    input  logic [snd_w-1:0] sample,
    output logic             pdm
);

    logic [snd_w-1:0] sample_ob;
    logic [snd_w-1:0] acc;

    // Flip the sign bit only for two's complement input
    assign sample_ob = sample ^ {signed_snd, {(snd_w-1){1'b0}}};

    // Carry out of the accumulator is the density bit
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            acc <= '0;
            pdm <= 1'b0;
        end else begin
            {pdm, acc} <= {1'b0, acc} + {1'b0, sample_ob};
        end
    end

endmodule

//--- hdl/video_expand.sv
// --------------------
// Registers colour and sync on pxl_cen, one pixel of latency
// Colour is black outside the active area
// --------------------

`timescale 1ns/1ps

module video_expand
    import frame_pkg::*;
(
    input  logic               clk_sys,
    input  logic               rst,
    input  logic               pxl_cen,
    input  logic [color_w-1:0] game_r,
    input  logic [color_w-1:0] game_g,
    input  logic [color_w-1:0] game_b,
    input  logic               lhbl,
    input  logic               lvbl,
    input  logic               hs,
    input  logic               vs,
    output logic [vga_w-1:0]   vga_r,
    output logic [vga_w-1:0]   vga_g,
    output logic [vga_w-1:0]   vga_b,
    output logic               vga_hs,
    output logic               vga_vs
);

    logic active;

    // Top bits repeated below so full scale stays full scale
    function automatic logic [vga_w-1:0] widen(input logic [color_w-1:0] c);
        widen = {c, c[color_w-1 -: vga_w-color_w]};
    endfunction

    assign active = lhbl & lvbl;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
            vga_hs <= 1'b0;
            vga_vs <= 1'b0;
        end else if (pxl_cen) begin
            vga_r  <= active ? widen(game_r) : '0;
            vga_g  <= active ? widen(game_g) : '0;
            vga_b  <= active ? widen(game_b) : '0;
            vga_hs <= hs;
            vga_vs <= vs;
        end
    end

    // Pixel enable is a single-cycle strobe
    a_cen_pulse: assert property (@(posedge clk_sys) pxl_cen |=> !pxl_cen)
        else $error("pxl_cen high for more than one cycle");

endmodule

//--- verification/frame_tb.sv
// --------------------
// Table driven testbench for frame_top
// Controller and status words are random with a fixed seed
// Flip and pause bits are held low in the random rows
// --------------------

`timescale 1ns/1ps

module frame_tb
    import frame_pkg::*;
;

    localparam int n_rows      = 6;
    localparam int cycle_limit = 2 * (n_rows * 1100 + 200);

    logic clk;
    logic reset, pll_locked, downloading, rst_req;
    logic [status_w-1:0] status;
    logic [board_joy_w-1:0] board_joystick1, board_joystick2;
    logic [color_w-1:0] game_r, game_g, game_b;
    logic lhbl, lvbl, hs, vs, pxl_cen;
    logic [snd_w-1:0] snd_left, snd_right;
    logic rst, game_rst, led, vga_hs, vga_vs, audio_l, audio_r;
    logic [vga_w-1:0] vga_r, vga_g, vga_b;
    logic [joy_w-1:0] game_joystick1, game_joystick2;
    logic [1:0] game_coin, game_start, dip_fxlevel;
    logic game_pause, game_service, dip_test, dip_pause, dip_flip, enable_fm, enable_psg;

    int errors = 0;
    int cycles = 0;

    // Stimulus table, colour is {r, g, b} and blanking is {lhbl, lvbl, hs, vs}
    string                  row_name   [n_rows];
    logic [status_w-1:0]    row_status [n_rows];
    logic [board_joy_w-1:0] row_joy1   [n_rows];
    logic [board_joy_w-1:0] row_joy2   [n_rows];
    logic [11:0]            row_color  [n_rows];
    logic [3:0]             row_blank  [n_rows];
    logic [snd_w-1:0]       row_sample [n_rows];

    frame_top dut_i (.clk_sys(clk), .*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Cycles until game_rst drops, sampled on falling edges
    task automatic count_until_game_rst_low(output int n);
        n = 0;
        while (game_rst !== 1'b0) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic fill_table();
        row_name   = '{"black", "white", "hblank", "vblank", "grey", "mixed"};
        row_color  = '{12'h000, 12'hfff, 12'hf80, 12'h3c5, 12'h777, 12'h9a1};
        row_blank  = '{4'b1100, 4'b1110, 4'b0111, 4'b1001, 4'b1111, 4'b1100};
        row_sample = '{16'h0000, 16'hffff, 16'h8000, 16'h03e8, 16'h3039, 16'hc350};
        for (int r = 0; r < n_rows; r++) begin
            row_status[r] = $urandom() & ~(32'h1 << st_flip_bit);
            row_joy1[r]   = 16'($urandom()) & ~(16'h1 << joy_pause_bit);
            row_joy2[r]   = 16'($urandom());
        end
    endtask

    function automatic logic [vga_w-1:0] expand_channel(input logic [color_w-1:0] c);
        return {c, c[color_w-1:color_w-2]};
    endfunction

    // Game inputs are the inverted board bits, bit 0 of coin and start is player 1
    task automatic check_inputs(input int r);
        logic [joy_w-1:0] e_joy1;
        logic [joy_w-1:0] e_joy2;
        logic [1:0]       e_coin;
        logic [1:0]       e_start;
        logic             e_service;
        logic             e_fm;
        logic             e_psg;
        logic [31:0]      st;
        st        = row_status[r];
        e_joy1    = ~row_joy1[r][joy_w-1:0];
        e_joy2    = ~row_joy2[r][joy_w-1:0];
        e_coin    = ~{row_joy2[r][joy_coin_bit], row_joy1[r][joy_coin_bit]};
        e_start   = ~{row_joy2[r][joy_start_bit], row_joy1[r][joy_start_bit]};
        e_service = ~row_joy1[r][joy_service_bit];
        e_fm      = ~st[st_nofm_bit];
        e_psg     = ~st[st_nopsg_bit];
        check({row_name[r], " joystick1"}, 32'(e_joy1), 32'(game_joystick1));
        check({row_name[r], " joystick2"}, 32'(e_joy2), 32'(game_joystick2));
        check({row_name[r], " coin"}, 32'(e_coin), 32'(game_coin));
        check({row_name[r], " start"}, 32'(e_start), 32'(game_start));
        check({row_name[r], " service"}, 32'(e_service), 32'(game_service));
        check({row_name[r], " pause"}, 32'(st[st_pause_bit]), 32'(game_pause));
        check({row_name[r], " dip_test"}, 32'(st[st_test_bit]), 32'(dip_test));
        check({row_name[r], " dip_pause"}, 32'(st[st_pause_bit]), 32'(dip_pause));
        check({row_name[r], " dip_flip"}, 32'(st[st_flip_bit]), 32'(dip_flip));
        check({row_name[r], " dip_fxlevel"}, 32'(st[st_fx_lsb +: 2]), 32'(dip_fxlevel));
        check({row_name[r], " enable_fm"}, 32'(e_fm), 32'(enable_fm));
        check({row_name[r], " enable_psg"}, 32'(e_psg), 32'(enable_psg));
    endtask

    task automatic check_video(input int r);
        logic             active;
        logic [vga_w-1:0] e_r;
        logic [vga_w-1:0] e_g;
        logic [vga_w-1:0] e_b;
        active = row_blank[r][3] & row_blank[r][2];
        e_r = active ? expand_channel(row_color[r][11:8]) : '0;
        e_g = active ? expand_channel(row_color[r][7:4]) : '0;
        e_b = active ? expand_channel(row_color[r][3:0]) : '0;
        check({row_name[r], " vga_r"}, 32'(e_r), 32'(vga_r));
        check({row_name[r], " vga_g"}, 32'(e_g), 32'(vga_g));
        check({row_name[r], " vga_b"}, 32'(e_b), 32'(vga_b));
        check({row_name[r], " vga_hs"}, 32'(row_blank[r][1]), 32'(vga_hs));
        check({row_name[r], " vga_vs"}, 32'(row_blank[r][0]), 32'(vga_vs));
    endtask

    // Ones over 1024 cycles may exceed the floor of sample / 64 by one
    task automatic check_density(input string name, input logic [snd_w-1:0] s, input int ones);
        int expected;
        expected = int'(s) * 1024 / 65536;
        if (ones != expected && ones != expected + 1)
            check(name, 32'(expected), 32'(ones));
    endtask

    initial begin
        int n;
        int ones_l;
        int ones_r;
        reset = 1'b1;
        pll_locked = 1'b1;
        downloading = 1'b0;
        rst_req = 1'b0;
        status = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        {game_r, game_g, game_b} = '0;
        {lhbl, lvbl, hs, vs} = '0;
        pxl_cen = 1'b0;
        snd_left = '0;
        snd_right = '0;
        void'($urandom(821));
        fill_table();

        // Reset state and release
        repeat (2) @(negedge clk);
        check("reset rst", 1, 32'(rst));
        check("reset game_rst", 1, 32'(game_rst));
        check("reset led", 0, 32'(led));
        check("reset joystick1", 32'({joy_w{1'b1}}), 32'(game_joystick1));
        check("reset joystick2", 32'({joy_w{1'b1}}), 32'(game_joystick2));
        check("reset coin", 3, 32'(game_coin));
        check("reset start", 3, 32'(game_start));
        check("reset service", 1, 32'(game_service));
        reset = 1'b0;
        count_until_game_rst_low(n);
        check("release game_rst delay", 32'(rst_hold + 1), 32'(n));
        check("release led", 1, 32'(led));

        // Game reset causes
        downloading = 1'b1;
        @(negedge clk);
        check("download game_rst", 1, 32'(game_rst));
        check("download led", 0, 32'(led));
        downloading = 1'b0;
        count_until_game_rst_low(n);
        check("download hold", 32'(rst_hold), 32'(n));
        rst_req = 1'b1;
        @(negedge clk);
        check("rst_req game_rst", 1, 32'(game_rst));
        rst_req = 1'b0;
        count_until_game_rst_low(n);
        check("rst_req hold", 32'(rst_hold), 32'(n));

        // Flip change pulse lasts one cycle ahead of the hold
        for (int f = 1; f >= 0; f--) begin
            status[st_flip_bit] = f[0];
            @(negedge clk);
            check($sformatf("flip to %0d dip_flip", f), 32'(f), 32'(dip_flip));
            check($sformatf("flip to %0d game_rst", f), 1, 32'(game_rst));
            count_until_game_rst_low(n);
            check($sformatf("flip to %0d hold", f), 32'(rst_hold + 1), 32'(n));
        end

        // Pause toggle from player 1
        for (int p = 0; p < 2; p++) begin
            board_joystick1[joy_pause_bit] = 1'b1;
            @(negedge clk);
            check($sformatf("pause press %0d", p), 32'(p == 0), 32'(game_pause));
            board_joystick1[joy_pause_bit] = 1'b0;
            @(negedge clk);
            check($sformatf("pause release %0d", p), 32'(p == 0), 32'(game_pause));
        end

        for (int r = 0; r < n_rows; r++) begin
            status = row_status[r];
            board_joystick1 = row_joy1[r];
            board_joystick2 = row_joy2[r];
            {game_r, game_g, game_b} = row_color[r];
            {lhbl, lvbl, hs, vs} = row_blank[r];
            snd_left = row_sample[r];
            snd_right = ~row_sample[r];
            pxl_cen = 1'b1;
            ones_l = 0;
            ones_r = 0;
            for (int i = 0; i < 1024; i++) begin
                @(negedge clk);
                if (i == 0) begin
                    pxl_cen = 1'b0;
                    check_inputs(r);
                    check_video(r);
                end
                if (audio_l)
                    ones_l++;
                if (audio_r)
                    ones_r++;
            end
            check_density({row_name[r], " audio_l"}, snd_left, ones_l);
            check_density({row_name[r], " audio_r"}, snd_right, ones_r);
        end

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
